// ==== source/tlp_stream_params.svh ====
// stream widths and core receive sideband field positions
`ifndef TLP_STREAM_PARAMS_SVH
`define TLP_STREAM_PARAMS_SVH

// ----------------------------------------
// stream geometry
// ----------------------------------------
`define TLP_DATA_W          128
`define TLP_DW_PER_BEAT     4
`define TLP_BAR_HIT_W       7

// ----------------------------------------
// core receive user field
// ----------------------------------------
`define RX_USER_W           22
`define RX_USER_SOF_BIT     14
`define RX_USER_SOF_QW_BIT  13
`define RX_USER_EOF_BIT     21
// 2-bit index of the last dword, low bit here
`define RX_USER_EOF_DW_LSB  19
`define RX_USER_BAR_LSB     2

`endif

// ==== source/tlp_stream_pkg.sv ====
// tlp stream data, keep, bar hit and receive sideband types
`default_nettype none

`include "tlp_stream_params.svh"

package tlp_stream_pkg;

    // one full beat and one half beat
    typedef logic [`TLP_DATA_W-1:0]     tlp_data_t;
    typedef logic [`TLP_DATA_W/2-1:0]   tlp_qw_t;

    // keep masks, one bit per dword or per byte
    typedef logic [`TLP_DW_PER_BEAT-1:0]    keep_dw_t;
    typedef logic [`TLP_DW_PER_BEAT*4-1:0]  keep_byte_t;

    typedef logic [`TLP_BAR_HIT_W-1:0]  bar_hit_t;

    // raw sideband as delivered by the core
    typedef logic [`RX_USER_W-1:0]      rx_user_t;

    // last dword index within a beat
    typedef logic [1:0]                 eof_dw_t;

endpackage

`default_nettype wire

// ==== source/rx_tlp_realign.sv ====
// receive realigner moving every tlp to dword 0 of an output beat
`timescale 1ns/1ns
`default_nettype none

`include "tlp_stream_params.svh"

module rx_tlp_realign (
    input  wire                             clk_pcie,
    input  wire                             rst,
    input  wire tlp_stream_pkg::tlp_data_t  core_rx_data,
    input  wire tlp_stream_pkg::rx_user_t   core_rx_user,
    input  wire                             core_rx_valid,
    output logic                            core_rx_ready,
    output tlp_stream_pkg::tlp_data_t       tlp_rx_data,
    output tlp_stream_pkg::keep_dw_t        tlp_rx_keep_dw,
    output logic                            tlp_rx_first,
    output logic                            tlp_rx_last,
    output tlp_stream_pkg::bar_hit_t        tlp_rx_bar_hit,
    output logic                            tlp_rx_valid
);
    import tlp_stream_pkg::*;

    // decoded input beat
    tlp_qw_t    rx_qw0;
    tlp_qw_t    rx_qw1;
    logic       rx_valid;
    logic       rx_sof;
    logic       rx_sof_qw;
    logic       rx_eof;
    eof_dw_t    rx_eof_dw;
    bar_hit_t   rx_bar_hit;

    // carry register holding the upper quadword of the previous beat
    logic       ready_q;
    logic       carry_valid;
    tlp_qw_t    carry_qw;
    logic       carry_sof;
    logic       carry_eof;
    logic       carry_eof_hi;
    bar_hit_t   carry_bar_hit;
    logic       carry_load;
    logic       split_end;

    // ----------------------------------------
    // sideband decode
    // ----------------------------------------
    assign rx_qw0     = core_rx_data[`TLP_DATA_W/2-1:0];
    assign rx_qw1     = core_rx_data[`TLP_DATA_W-1:`TLP_DATA_W/2];
    // beat re-offered after a withheld ready was already taken
    assign rx_valid   = core_rx_valid && ready_q;
    assign rx_sof     = core_rx_user[`RX_USER_SOF_BIT];
    assign rx_sof_qw  = core_rx_user[`RX_USER_SOF_QW_BIT];
    assign rx_eof     = core_rx_user[`RX_USER_EOF_BIT];
    assign rx_eof_dw  = core_rx_user[`RX_USER_EOF_DW_LSB +: 2];
    assign rx_bar_hit = core_rx_user[`RX_USER_BAR_LSB +: `TLP_BAR_HIT_W];

    // carried tlp ending in dword 2 or 3 needs a second output beat
    assign split_end     = carry_valid && rx_valid && rx_eof && rx_eof_dw[1];
    assign core_rx_ready = !split_end;

    // ----------------------------------------
    // output beat
    // ----------------------------------------
    assign tlp_rx_data    = carry_valid ? {rx_qw0, carry_qw} : core_rx_data;
    assign tlp_rx_bar_hit = carry_valid ? carry_bar_hit : rx_bar_hit;
    assign tlp_rx_first   = carry_valid ? carry_sof : (rx_sof && !rx_sof_qw);
    assign tlp_rx_last    = carry_valid ?
                            (carry_eof || (rx_valid && rx_eof && !rx_eof_dw[1])) : rx_eof;

    // a tlp starting in the upper quadword alone produces nothing yet
    assign tlp_rx_valid = carry_valid || (rx_valid && (rx_eof || !(rx_sof && rx_sof_qw)));

    always_comb begin
        if (carry_valid) begin
            tlp_rx_keep_dw[0] = 1'b1;
            tlp_rx_keep_dw[1] = !carry_eof || carry_eof_hi;
            tlp_rx_keep_dw[2] = !carry_eof && rx_valid;
            tlp_rx_keep_dw[3] = !carry_eof && rx_valid && (!rx_eof || rx_eof_dw != 2'd0);
        end else begin
            tlp_rx_keep_dw[0] = rx_valid;
            tlp_rx_keep_dw[1] = !rx_eof || rx_eof_dw != 2'd0;
            tlp_rx_keep_dw[2] = !rx_eof || rx_eof_dw[1];
            tlp_rx_keep_dw[3] = !rx_eof || rx_eof_dw == 2'd3;
        end
    end

    // ----------------------------------------
    // carry control
    // ----------------------------------------
    always_comb begin
        if (carry_valid) begin
            // mid-tlp beat or new upper start or end spilling past dword 1
            carry_load = rx_valid && ((!rx_sof && !rx_eof) || (rx_sof && rx_sof_qw) ||
                                      (rx_eof && rx_eof_dw[1]));
        end else begin
            carry_load = rx_valid && rx_sof && rx_sof_qw;
        end
    end

    always_ff @(posedge clk_pcie) begin
        if (rst) begin
            ready_q     <= 1'b1;
            carry_valid <= 1'b0;
        end else begin
            ready_q     <= core_rx_ready;
            carry_valid <= carry_load;
        end
    end

    always_ff @(posedge clk_pcie) begin
        if (rx_valid) begin
            carry_qw      <= rx_qw1;
            carry_sof     <= rx_sof && rx_sof_qw;
            carry_eof     <= rx_eof && rx_eof_dw[1];
            carry_eof_hi  <= rx_eof_dw == 2'd3;
            carry_bar_hit <= rx_bar_hit;
        end
    end

    // ----------------------------------------
    // assertions
    // ----------------------------------------
    keep_dw0_set: assert property (@(posedge clk_pcie) disable iff (rst)
        tlp_rx_valid |-> tlp_rx_keep_dw[0]);

    // withheld ready lasts one cycle only
    ready_single_gap: assert property (@(posedge clk_pcie) disable iff (rst)
        (core_rx_valid && !core_rx_ready) |=> (core_rx_ready || !core_rx_valid));

endmodule

`default_nettype wire

// ==== source/tx_tlp_stage.sv ====
// transmit hold stage and dword to byte keep expansion
`timescale 1ns/1ns
`default_nettype none

`include "tlp_stream_params.svh"

module tx_tlp_stage (
    input  wire                             clk_pcie,
    input  wire                             rst,
    input  wire tlp_stream_pkg::tlp_data_t  tx_in_data,
    input  wire tlp_stream_pkg::keep_dw_t   tx_in_keep_dw,
    input  wire                             tx_in_last,
    input  wire                             tx_in_valid,
    output logic                            tx_in_ready,
    output tlp_stream_pkg::tlp_data_t       core_tx_data,
    output tlp_stream_pkg::keep_byte_t      core_tx_keep,
    output logic                            core_tx_last,
    output logic                            core_tx_valid,
    input  wire                             core_tx_ready
);
    import tlp_stream_pkg::*;

    logic       hold_valid;
    logic       hold_load;
    tlp_data_t  hold_data;
    keep_dw_t   hold_keep_dw;
    logic       hold_last;
    keep_dw_t   out_keep_dw;

    // beat taken while the core stalls
    assign hold_load   = tx_in_valid && !hold_valid && !core_tx_ready;
    assign tx_in_ready = !hold_valid;

    always_ff @(posedge clk_pcie) begin
        if (rst) begin
            hold_valid <= 1'b0;
        end else if (hold_valid) begin
            hold_valid <= !core_tx_ready;
        end else begin
            hold_valid <= hold_load;
        end
    end

    always_ff @(posedge clk_pcie) begin
        if (hold_load) begin
            hold_data    <= tx_in_data;
            hold_keep_dw <= tx_in_keep_dw;
            hold_last    <= tx_in_last;
        end
    end

    // ----------------------------------------
    // output mux with held beat first
    // ----------------------------------------
    assign core_tx_valid = hold_valid || tx_in_valid;
    assign core_tx_data  = hold_valid ? hold_data : tx_in_data;
    assign core_tx_last  = hold_valid ? hold_last : tx_in_last;
    assign out_keep_dw   = hold_valid ? hold_keep_dw : tx_in_keep_dw;

    // each dword bit covers four byte lanes
    for (genvar i = 0; i < `TLP_DW_PER_BEAT; i++) begin : g_keep_byte
        assign core_tx_keep[4*i +: 4] = {4{out_keep_dw[i]}};
    end

    hold_stable: assert property (@(posedge clk_pcie) disable iff (rst)
        (hold_valid && !core_tx_ready) |=> (core_tx_valid && $stable(core_tx_data)));

endmodule

`default_nettype wire

// ==== source/tlp_stream_top.sv ====
// top level with the receive realigner and the transmit stage
`timescale 1ns/1ns
`default_nettype none

module tlp_stream_top (
    input  wire                             clk_pcie,
    input  wire                             rst,

    // receive from the core
    input  wire tlp_stream_pkg::tlp_data_t  core_rx_data,
    input  wire tlp_stream_pkg::rx_user_t   core_rx_user,
    input  wire                             core_rx_valid,
    output logic                            core_rx_ready,

    // realigned receive stream
    output tlp_stream_pkg::tlp_data_t       tlp_rx_data,
    output tlp_stream_pkg::keep_dw_t        tlp_rx_keep_dw,
    output logic                            tlp_rx_first,
    output logic                            tlp_rx_last,
    output tlp_stream_pkg::bar_hit_t        tlp_rx_bar_hit,
    output logic                            tlp_rx_valid,

    // transmit from the tlp logic
    input  wire tlp_stream_pkg::tlp_data_t  tx_in_data,
    input  wire tlp_stream_pkg::keep_dw_t   tx_in_keep_dw,
    input  wire                             tx_in_last,
    input  wire                             tx_in_valid,
    output logic                            tx_in_ready,

    // transmit to the core
    output tlp_stream_pkg::tlp_data_t       core_tx_data,
    output tlp_stream_pkg::keep_byte_t      core_tx_keep,
    output logic                            core_tx_last,
    output logic                            core_tx_valid,
    input  wire                             core_tx_ready
);

    // ----------------------------------------
    // receive path
    // ----------------------------------------
    rx_tlp_realign i_rx_tlp_realign (
        .clk_pcie       (clk_pcie),
        .rst            (rst),
        .core_rx_data   (core_rx_data),
        .core_rx_user   (core_rx_user),
        .core_rx_valid  (core_rx_valid),
        .core_rx_ready  (core_rx_ready),
        .tlp_rx_data    (tlp_rx_data),
        .tlp_rx_keep_dw (tlp_rx_keep_dw),
        .tlp_rx_first   (tlp_rx_first),
        .tlp_rx_last    (tlp_rx_last),
        .tlp_rx_bar_hit (tlp_rx_bar_hit),
        .tlp_rx_valid   (tlp_rx_valid)
    );

    // ----------------------------------------
    // transmit path
    // ----------------------------------------
    tx_tlp_stage i_tx_tlp_stage (
        .clk_pcie       (clk_pcie),
        .rst            (rst),
        .tx_in_data     (tx_in_data),
        .tx_in_keep_dw  (tx_in_keep_dw),
        .tx_in_last     (tx_in_last),
        .tx_in_valid    (tx_in_valid),
        .tx_in_ready    (tx_in_ready),
        .core_tx_data   (core_tx_data),
        .core_tx_keep   (core_tx_keep),
        .core_tx_last   (core_tx_last),
        .core_tx_valid  (core_tx_valid),
        .core_tx_ready  (core_tx_ready)
    );

endmodule

`default_nettype wire

// ==== verification/tb_tlp_stream.sv ====
// testbench with random receive and transmit traffic, reference model queues and checks
`timescale 1ns/1ns
`default_nettype none

`include "tlp_stream_params.svh"

module tb_tlp_stream;
    import tlp_stream_pkg::*;

    localparam int NUM_RX_TLP  = 150;
    localparam int NUM_TX_TLP  = 150;
    localparam int WAIT_LIMIT  = 1000;
    localparam int DRIVE_DELAY = 10;

    logic clk_pcie, rst;
    tlp_data_t core_rx_data, tlp_rx_data, tx_in_data, core_tx_data;
    rx_user_t core_rx_user;
    keep_dw_t tlp_rx_keep_dw, tx_in_keep_dw;
    keep_byte_t core_tx_keep;
    bar_hit_t tlp_rx_bar_hit;
    logic core_rx_valid, core_rx_ready, tlp_rx_first, tlp_rx_last, tlp_rx_valid;
    logic tx_in_last, tx_in_valid, tx_in_ready, core_tx_last, core_tx_valid, core_tx_ready;

    integer seed;
    integer errors;

    // stimulus and expected values
    tlp_data_t rx_beat_data[$], tx_beat_data[$], exp_tx_data[$];
    rx_user_t rx_beat_user[$];
    keep_dw_t tx_beat_keep[$], exp_tx_keep[$];
    logic tx_beat_last[$], exp_tx_last[$];
    int rx_gap[$], tx_gap[$], exp_len[$];
    logic [31:0] exp_dw[$], got_dw[$];
    bar_hit_t exp_bar[$];

    // receive beat under construction
    tlp_data_t cur_data;
    rx_user_t cur_user;
    int cur_pos;
    bar_hit_t cur_bar, got_bar;
    logic in_tlp, stall_seen, stall_last;
    tlp_data_t stall_data;

    tlp_stream_top UUT (.*);

    initial begin
        clk_pcie = 1'b0;
        forever #50 clk_pcie = ~clk_pcie;
    end

    task automatic report_mismatch(input string name, input logic [127:0] exp, act);
        $display("FAILED %s: expected %0h, actual %0h", name, exp, act);
        errors++;
    endtask

    task automatic report_error(input string what);
        $display("ERROR: %s", what);
        errors++;
    endtask

    task automatic timeout_stop(input string what);
        $display("timeout while waiting for %s", what);
        $display("summary: %0d errors before the timeout", errors);
        $display("Checks failed");
        $finish;
    endtask

    function automatic tlp_data_t random_beat();
        tlp_data_t d;
        for (int w = 0; w < 4; w++) d[32*w +: 32] = $random(seed);
        return d;
    endfunction

    // ----------------------------------------
    // receive packing into dword slots
    // ----------------------------------------
    task automatic flush_beat();
        rx_beat_data.push_back(cur_data);
        rx_beat_user.push_back(cur_user);
        rx_gap.push_back(($unsigned($random(seed)) % 4 == 0) ? 1 : 0);
        cur_data = random_beat();
        cur_user = '0;
        cur_user[`RX_USER_BAR_LSB +: `TLP_BAR_HIT_W] = cur_bar;
        cur_pos = 0;
    endtask

    task automatic put_dword(input logic [31:0] dw, input logic sof, input logic eof);
        cur_data[32*cur_pos +: 32] = dw;
        if (sof) begin
            cur_user[`RX_USER_SOF_BIT] = 1'b1;
            cur_user[`RX_USER_SOF_QW_BIT] = (cur_pos == 2);
            cur_user[`RX_USER_BAR_LSB +: `TLP_BAR_HIT_W] = cur_bar;
        end
        if (eof) begin
            cur_user[`RX_USER_EOF_BIT] = 1'b1;
            cur_user[`RX_USER_EOF_DW_LSB +: 2] = 2'(cur_pos);
        end
        cur_pos++;
        if (cur_pos == 4) flush_beat();
    endtask

    task automatic build_rx_tlp();
        int len;
        int start;
        logic [31:0] dw;
        len = 3 + $unsigned($random(seed)) % 10;
        start = ($random(seed) & 1) ? 2 : 0;
        cur_bar = $random(seed);
        // upper start may share a beat with an end in dword 0 or 1
        if (cur_pos > 2 || (cur_pos > 0 && start == 0)) flush_beat();
        if (start == 2) cur_pos = 2;
        exp_len.push_back(len);
        exp_bar.push_back(cur_bar);
        for (int i = 0; i < len; i++) begin
            dw = $random(seed);
            exp_dw.push_back(dw);
            put_dword(dw, i == 0, i == len - 1);
        end
    endtask

    task automatic build_tx_tlp();
        int nbeats;
        nbeats = 1 + $unsigned($random(seed)) % 4;
        for (int b = 0; b < nbeats; b++) begin
            tx_beat_data.push_back(random_beat());
            tx_beat_last.push_back(b == nbeats - 1);
            tx_beat_keep.push_back((b == nbeats - 1) ? 4'hf >> ($unsigned($random(seed)) % 4)
                                                     : 4'hf);
            tx_gap.push_back(($unsigned($random(seed)) % 4 == 0) ? 1 : 0);
        end
    endtask

    // ----------------------------------------
    // drivers acting as core and as producer
    // ----------------------------------------
    task automatic wait_reset_release();
        int cnt;
        cnt = 0;
        while (rst) begin
            @(posedge clk_pcie);
            cnt++;
            if (cnt > WAIT_LIMIT) timeout_stop("reset release");
        end
    endtask

    task automatic drive_rx();
        int cnt;
        wait_reset_release();
        @(posedge clk_pcie);
        #DRIVE_DELAY;
        while (rx_beat_data.size() > 0) begin
            repeat (rx_gap.pop_front()) begin
                @(posedge clk_pcie);
                #DRIVE_DELAY;
            end
            core_rx_data = rx_beat_data.pop_front();
            core_rx_user = rx_beat_user.pop_front();
            core_rx_valid = 1'b1;
            cnt = 0;
            @(negedge clk_pcie);
            while (!core_rx_ready) begin
                cnt++;
                if (cnt > WAIT_LIMIT) timeout_stop("core_rx_ready");
                @(negedge clk_pcie);
            end
            @(posedge clk_pcie);
            #DRIVE_DELAY;
            core_rx_valid = 1'b0;
        end
    endtask

    task automatic drive_tx();
        int cnt;
        wait_reset_release();
        @(posedge clk_pcie);
        #DRIVE_DELAY;
        while (tx_beat_data.size() > 0) begin
            repeat (tx_gap.pop_front()) begin
                @(posedge clk_pcie);
                #DRIVE_DELAY;
            end
            tx_in_data = tx_beat_data.pop_front();
            tx_in_keep_dw = tx_beat_keep.pop_front();
            tx_in_last = tx_beat_last.pop_front();
            tx_in_valid = 1'b1;
            cnt = 0;
            @(negedge clk_pcie);
            while (!tx_in_ready) begin
                cnt++;
                if (cnt > WAIT_LIMIT) timeout_stop("tx_in_ready");
                @(negedge clk_pcie);
            end
            @(posedge clk_pcie);
            #DRIVE_DELAY;
            tx_in_valid = 1'b0;
        end
    endtask

    // random core back-pressure on transmit
    initial begin
        forever begin
            @(posedge clk_pcie);
            #DRIVE_DELAY;
            core_tx_ready = ($unsigned($random(seed)) % 4) != 0;
        end
    end

    // ----------------------------------------
    // monitors
    // ----------------------------------------
    task automatic compare_rx_tlp();
        int len;
        bar_hit_t bar;
        logic [31:0] dw;
        if (exp_len.size() == 0) begin
            report_error("receive TLP arrived with none expected");
        end else begin
            len = exp_len.pop_front();
            bar = exp_bar.pop_front();
            if (got_bar !== bar) report_mismatch("rx_bar_hit", bar, got_bar);
            if (got_dw.size() != len) report_mismatch("rx_tlp_length", len, got_dw.size());
            for (int i = 0; i < len; i++) begin
                dw = exp_dw.pop_front();
                if (i < got_dw.size() && got_dw[i] !== dw)
                    report_mismatch("rx_tlp_dword", dw, got_dw[i]);
            end
        end
    endtask

    task automatic check_rx_beat();
        if (!tlp_rx_keep_dw[0] || (tlp_rx_keep_dw & (tlp_rx_keep_dw + 4'd1)) != 4'd0)
            report_error($sformatf("receive keep %b not contiguous from dword 0", tlp_rx_keep_dw));
        if (tlp_rx_first) begin
            if (in_tlp) report_error("tlp_rx_first seen before the previous TLP ended");
            in_tlp = 1'b1;
            got_bar = tlp_rx_bar_hit;
            got_dw.delete();
        end else if (!in_tlp) begin
            report_error("receive beat outside a TLP without tlp_rx_first");
        end
        for (int i = 0; i < 4; i++) begin
            if (tlp_rx_keep_dw[i]) got_dw.push_back(tlp_rx_data[32*i +: 32]);
        end
        if (tlp_rx_last) begin
            in_tlp = 1'b0;
            compare_rx_tlp();
        end
    endtask

    task automatic check_tx_beat();
        keep_dw_t keep;
        if (exp_tx_data.size() == 0) begin
            report_error("transmit beat reached the core with none expected");
        end else begin
            keep = exp_tx_keep.pop_front();
            if (core_tx_data !== exp_tx_data[0]) report_mismatch("tx_data", exp_tx_data[0],
                                                                 core_tx_data);
            if (core_tx_last !== exp_tx_last[0]) report_mismatch("tx_last", exp_tx_last[0],
                                                                 core_tx_last);
            // four byte lanes per dword bit
            for (int i = 0; i < 4; i++) begin
                if (core_tx_keep[4*i +: 4] !== {4{keep[i]}})
                    report_mismatch("tx_keep_bytes", {4{keep[i]}}, core_tx_keep[4*i +: 4]);
            end
            void'(exp_tx_data.pop_front());
            void'(exp_tx_last.pop_front());
        end
    endtask

    always @(negedge clk_pcie) begin
        if (rst) begin
            if (tlp_rx_valid !== 1'b0) report_error("tlp_rx_valid high during reset");
            if (core_tx_valid !== 1'b0) report_error("core_tx_valid high during reset");
            stall_seen = 1'b0;
        end else begin
            if (tlp_rx_valid) check_rx_beat();
            if (tx_in_valid && tx_in_ready) begin
                exp_tx_data.push_back(tx_in_data);
                exp_tx_keep.push_back(tx_in_keep_dw);
                exp_tx_last.push_back(tx_in_last);
            end
            if (stall_seen) begin
                if (!core_tx_valid) report_error("core_tx_valid dropped under back-pressure");
                if (core_tx_data !== stall_data) report_mismatch("tx_hold_data", stall_data,
                                                                 core_tx_data);
                if (core_tx_last !== stall_last) report_mismatch("tx_hold_last", stall_last,
                                                                 core_tx_last);
            end
            if (core_tx_valid && core_tx_ready) check_tx_beat();
            stall_seen = core_tx_valid && !core_tx_ready;
            stall_data = core_tx_data;
            stall_last = core_tx_last;
        end
    end

    task automatic wait_drain();
        int cnt;
        cnt = 0;
        while (exp_len.size() > 0 || exp_tx_data.size() > 0) begin
            @(posedge clk_pcie);
            cnt++;
            if (cnt > WAIT_LIMIT) timeout_stop("model queues to drain");
        end
    endtask

    // ----------------------------------------
    // main sequence
    // ----------------------------------------
    initial begin
        seed = 20114;
        errors = 0;
        rst = 1'b1;
        core_rx_data = '0;
        core_rx_user = '0;
        core_rx_valid = 1'b0;
        tx_in_data = '0;
        tx_in_keep_dw = '0;
        tx_in_last = 1'b0;
        tx_in_valid = 1'b0;
        core_tx_ready = 1'b0;
        in_tlp = 1'b0;
        stall_seen = 1'b0;
        cur_pos = 0;
        cur_bar = '0;
        cur_user = '0;
        cur_data = random_beat();
        for (int t = 0; t < NUM_RX_TLP; t++) build_rx_tlp();
        if (cur_pos > 0) flush_beat();
        for (int t = 0; t < NUM_TX_TLP; t++) build_tx_tlp();

        repeat (10) @(posedge clk_pcie);
        #DRIVE_DELAY;
        rst = 1'b0;
        @(negedge clk_pcie);
        if (tlp_rx_valid !== 1'b0) report_error("tlp_rx_valid high right after reset");
        if (core_tx_valid !== 1'b0) report_error("core_tx_valid high right after reset");

        fork
            drive_rx();
            drive_tx();
        join
        wait_drain();
        if (exp_dw.size() != 0 || in_tlp) report_error("receive TLP left unfinished");

        $display("summary: %0d errors", errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+source
source/tlp_stream_pkg.sv
source/rx_tlp_realign.sv
source/tx_tlp_stage.sv
source/tlp_stream_top.sv
verification/tb_tlp_stream.sv

// ==== Bender.yml ====
package:
  name: tlp_stream

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/tlp_stream_pkg.sv
      - source/rx_tlp_realign.sv
      - source/tx_tlp_stage.sv
      - source/tlp_stream_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - verification/tb_tlp_stream.sv
